// ==== Makefile ====
# Verilator build and run for the transmit path testbench

VERILATOR ?= verilator
TOP       ?= tb_emesh_tx
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation passed

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== filelist.f ====
rtl/emesh_tx_pkg.sv
rtl/tx_fifo.sv
rtl/priority_arbiter.sv
rtl/tx_arbiter.sv
rtl/tx_cfg_apb.sv
rtl/emesh_tx_top.sv
verif/emesh_tx_sva.sv
verif/tb_emesh_tx.sv

// ==== rtl/emesh_tx_pkg.sv ====
// Packet layout, stream indices, queue sizing and register map of the transmit path
package emesh_tx_pkg;

  // ############################
  // Packet layout
  // ############################

  // Full emesh packet width
  localparam int PW = 104;

  // Set for writes, clear for read requests and responses
  localparam int WRITE_BIT = 1;

  // Control mode field, bits 7 to 4
  localparam int CTRLMODE_LSB = 4;
  localparam int CTRLMODE_W = 4;

  // ############################
  // Streams and queues
  // ############################

  // Lower index wins arbitration
  localparam int NUM_CH = 3;
  localparam int CH_WR = 0;
  localparam int CH_RD = 1;
  localparam int CH_RR = 2;

  // Entries per stream queue
  localparam int FIFO_DEPTH = 4;
  localparam int PTR_W = $clog2(FIFO_DEPTH);
  // One extra bit so a full queue is distinct from empty
  localparam int CNT_W = PTR_W + 1;

  // ############################
  // Register map
  // ############################
  localparam logic [11:0] ADDR_CTRL = 12'h000;
  localparam logic [11:0] ADDR_STATUS = 12'h004;
  localparam logic [11:0] ADDR_COUNT = 12'h008;

  // Control register fields
  localparam int CTRL_EN_BIT = 0;
  localparam int CTRL_BYP_BIT = 1;
  localparam int CTRL_MODE_LSB = 4;

endpackage

// ==== rtl/emesh_tx_top.sv ====
// Transmit top: three stream queues, arbiter with output register, APB register block
`timescale 1ns/1ps

module emesh_tx_top import emesh_tx_pkg::*;
(
  input  logic          clk,
  input  logic          rst,
  // Host writes
  input  logic          txwr_access,
  input  logic [PW-1:0] txwr_packet,
  output logic          txwr_wait,
  // Host read requests
  input  logic          txrd_access,
  input  logic [PW-1:0] txrd_packet,
  output logic          txrd_wait,
  // Read responses
  input  logic          txrr_access,
  input  logic [PW-1:0] txrr_packet,
  output logic          txrr_wait,
  // Pin side
  output logic          etx_access,
  output logic [PW-1:0] etx_packet,
  output logic          etx_rr,
  input  logic          etx_wr_wait,
  input  logic          etx_rd_wait,
  // APB
  input  logic [11:0]   paddr,
  input  logic          psel,
  input  logic          penable,
  input  logic          pwrite,
  input  logic [31:0]   pwdata,
  output logic [31:0]   prdata,
  output logic          pready,
  output logic          pslverr
);

  logic [NUM_CH-1:0]     ch_valid;
  logic [NUM_CH-1:0]     ch_pop;
  logic [PW-1:0]         wr_head;
  logic [PW-1:0]         rd_head;
  logic [PW-1:0]         rr_head;
  logic                  sent;
  logic                  cfg_wait;
  logic                  ctrlmode_bypass;
  logic [CTRLMODE_W-1:0] ctrlmode;

  // ############################
  // Stream queues
  // ############################
  tx_fifo fifo_wr
  (
    .clk(clk), .rst(rst),
    .push_access(txwr_access), .push_packet(txwr_packet), .push_wait(txwr_wait),
    .pop(ch_pop[CH_WR]), .valid(ch_valid[CH_WR]), .head(wr_head)
  );

  tx_fifo fifo_rd
  (
    .clk(clk), .rst(rst),
    .push_access(txrd_access), .push_packet(txrd_packet), .push_wait(txrd_wait),
    .pop(ch_pop[CH_RD]), .valid(ch_valid[CH_RD]), .head(rd_head)
  );

  tx_fifo fifo_rr
  (
    .clk(clk), .rst(rst),
    .push_access(txrr_access), .push_packet(txrr_packet), .push_wait(txrr_wait),
    .pop(ch_pop[CH_RR]), .valid(ch_valid[CH_RR]), .head(rr_head)
  );

  // ############################
  // Arbiter and output register
  // ############################
  tx_arbiter u_arb
  (
    .clk(clk), .rst(rst),
    .ch_valid(ch_valid), .wr_head(wr_head), .rd_head(rd_head), .rr_head(rr_head),
    .ch_pop(ch_pop),
    .etx_wr_wait(etx_wr_wait), .etx_rd_wait(etx_rd_wait),
    .etx_access(etx_access), .etx_rr(etx_rr), .etx_packet(etx_packet),
    .cfg_wait(cfg_wait), .ctrlmode_bypass(ctrlmode_bypass), .ctrlmode(ctrlmode),
    .sent(sent)
  );

  // Register block
  tx_cfg_apb u_cfg
  (
    .clk(clk), .rst(rst),
    .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
    .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .ch_valid(ch_valid), .sent(sent),
    .cfg_wait(cfg_wait), .ctrlmode_bypass(ctrlmode_bypass), .ctrlmode(ctrlmode)
  );

endmodule

// ==== rtl/priority_arbiter.sv ====
// Fixed priority arbiter with grant and held-off flags per request
`timescale 1ns/1ps

module priority_arbiter import emesh_tx_pkg::*;
(
  input  logic [NUM_CH-1:0] request,
  output logic [NUM_CH-1:0] grant,
  output logic [NUM_CH-1:0] await
);

  // Running OR of all higher ranked requests
  logic [NUM_CH-1:0] higher;

  always_comb
  begin
    higher = '0;
    for (int i = 1; i < NUM_CH; i++)
    begin
      higher[i] = higher[i-1] | request[i-1];
    end
  end

  // ############################
  // Grant and hold-off
  // ############################

  // Lowest index active request wins
  assign grant = request & ~higher;

  // Active but blocked by a higher ranked stream
  assign await = request & higher;

endmodule

// ==== rtl/tx_arbiter.sv ====
// Control mode insertion, stream arbitration, packet mux and stalling output register
`timescale 1ns/1ps

module tx_arbiter import emesh_tx_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  // Queue heads
  input  logic [NUM_CH-1:0]     ch_valid,
  input  logic [PW-1:0]         wr_head,
  input  logic [PW-1:0]         rd_head,
  input  logic [PW-1:0]         rr_head,
  output logic [NUM_CH-1:0]     ch_pop,
  // Pin side
  input  logic                  etx_wr_wait,
  input  logic                  etx_rd_wait,
  output logic                  etx_access,
  output logic                  etx_rr,
  output logic [PW-1:0]         etx_packet,
  // Configuration
  input  logic                  cfg_wait,
  input  logic                  ctrlmode_bypass,
  input  logic [CTRLMODE_W-1:0] ctrlmode,
  // Handoff pulse for the send counter
  output logic                  sent
);

  logic [PW-1:0]     wr_data;
  logic [PW-1:0]     rd_data;
  logic [PW-1:0]     mux_packet;
  logic [NUM_CH-1:0] request;
  logic [NUM_CH-1:0] grant;
  logic              any_grant;
  logic              held_wait;
  logic              handoff;
  logic              load_ok;

  // ############################
  // Control mode insertion
  // ############################

  // Writes and read requests take the configured mode
  always_comb
  begin
    wr_data = wr_head;
    rd_data = rd_head;
    if (ctrlmode_bypass)
    begin
      wr_data[CTRLMODE_LSB +: CTRLMODE_W] = ctrlmode;
      rd_data[CTRLMODE_LSB +: CTRLMODE_W] = ctrlmode;
    end
  end

  // ############################
  // Arbitration
  // ############################

  // Configuration wait blocks every stream
  assign request = ch_valid & {NUM_CH{~cfg_wait}};

  // Fixed priority over the masked requests
  priority_arbiter u_prio
  (
    .request (request),
    .grant   (grant),
    .await   ()
  );

  assign any_grant = |grant;

  // One-hot AND-OR mux
  assign mux_packet = ({PW{grant[CH_WR]}} & wr_data)
                    | ({PW{grant[CH_RD]}} & rd_data)
                    | ({PW{grant[CH_RR]}} & rr_head);

  // ############################
  // Output stage
  // ############################

  // Held packet stalls on the wait of its own direction
  assign held_wait = etx_packet[WRITE_BIT] ? etx_wr_wait : etx_rd_wait;
  assign handoff = etx_access & ~held_wait;

  // Empty, or emptying this cycle
  assign load_ok = ~etx_access | handoff;

  // Head leaves its queue in the same cycle it is loaded
  assign ch_pop = grant & {NUM_CH{load_ok}};

  assign sent = handoff;

  // Access and stream marker
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      etx_access <= 1'b0;
      etx_rr     <= 1'b0;
    end
    else if (load_ok)
    begin
      etx_access <= any_grant;
      etx_rr     <= grant[CH_RR];
    end
  end

  // Payload only moves on a real load
  always_ff @(posedge clk)
  begin
    if (load_ok && any_grant)
    begin
      etx_packet <= mux_packet;
    end
  end

endmodule

// ==== rtl/tx_cfg_apb.sv ====
// APB register block: control, queue status, sent-packet counter, configuration wait
`timescale 1ns/1ps

module tx_cfg_apb import emesh_tx_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  // APB slave
  input  logic [11:0]           paddr,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [31:0]           pwdata,
  output logic [31:0]           prdata,
  output logic                  pready,
  output logic                  pslverr,
  // Datapath status
  input  logic [NUM_CH-1:0]     ch_valid,
  input  logic                  sent,
  // Settings out
  output logic                  cfg_wait,
  output logic                  ctrlmode_bypass,
  output logic [CTRLMODE_W-1:0] ctrlmode
);

  logic        tx_enable;
  logic [31:0] sent_count;
  logic        addr_hit;
  logic        wr_en;
  logic        rd_en;

  // ############################
  // APB decode
  // ############################
  assign addr_hit = (paddr == ADDR_CTRL) || (paddr == ADDR_STATUS)
                 || (paddr == ADDR_COUNT);

  // Zero wait states
  assign pready = 1'b1;
  assign wr_en = psel & penable & pwrite;
  assign rd_en = psel & ~pwrite;
  assign pslverr = psel & penable & ~addr_hit;

  // Transmit disabled halts all streams
  assign cfg_wait = ~tx_enable;

  // Control register
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      tx_enable       <= 1'b0;
      ctrlmode_bypass <= 1'b0;
      ctrlmode        <= '0;
    end
    else if (wr_en && (paddr == ADDR_CTRL))
    begin
      tx_enable       <= pwdata[CTRL_EN_BIT];
      ctrlmode_bypass <= pwdata[CTRL_BYP_BIT];
      ctrlmode        <= pwdata[CTRL_MODE_LSB +: CTRLMODE_W];
    end
  end

  // Sent counter cleared by any write even during a handoff
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      sent_count <= '0;
    end
    else if (wr_en && (paddr == ADDR_COUNT))
    begin
      sent_count <= '0;
    end
    else if (sent)
    begin
      sent_count <= sent_count + 1'b1;
    end
  end

  // ############################
  // Read mux
  // ############################
  always_comb
  begin
    prdata = '0;
    if (rd_en)
    begin
      case (paddr)
        ADDR_CTRL:
        begin
          prdata[CTRL_EN_BIT]                      = tx_enable;
          prdata[CTRL_BYP_BIT]                     = ctrlmode_bypass;
          prdata[CTRL_MODE_LSB +: CTRLMODE_W]      = ctrlmode;
        end
        ADDR_STATUS: prdata[NUM_CH-1:0] = ch_valid;
        ADDR_COUNT:  prdata = sent_count;
        default:     prdata = '0;
      endcase
    end
  end

endmodule

// ==== rtl/tx_fifo.sv ====
// Stream queue: access/wait push side, valid/pop read side
`timescale 1ns/1ps

module tx_fifo import emesh_tx_pkg::*;
(
  input  logic          clk,
  input  logic          rst,
  // Push side from the stream source
  input  logic          push_access,
  input  logic [PW-1:0] push_packet,
  output logic          push_wait,
  // Read side towards the arbiter
  input  logic          pop,
  output logic          valid,
  output logic [PW-1:0] head
);

  // Entry storage
  logic [PW-1:0]    mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             do_push;
  logic             do_pop;

  assign full = (count == CNT_W'(FIFO_DEPTH));
  assign valid = (count != '0);
  assign head = mem[rd_ptr];

  // Pop only ever removes a real entry
  assign do_pop = pop & valid;

  // Full queue still takes a packet when the head leaves this cycle
  assign push_wait = full & ~do_pop;
  assign do_push = push_access & ~push_wait;

  // ############################
  // Storage
  // ############################
  always_ff @(posedge clk)
  begin
    if (do_push)
    begin
      mem[wr_ptr] <= push_packet;
    end
  end

  // ############################
  // Pointers and fill count
  // ############################
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      // Depth is a power of two so pointers wrap naturally
      if (do_push)
      begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== verif/emesh_tx_sva.sv ====
// Bound checks on the arbiter output handshake and grant rules
`timescale 1ns/1ps

module emesh_tx_sva import emesh_tx_pkg::*;
(
  input logic              clk,
  input logic              rst,
  input logic [NUM_CH-1:0] grant,
  input logic              cfg_wait,
  input logic              etx_access,
  input logic              etx_wr_wait,
  input logic              etx_rd_wait,
  input logic [PW-1:0]     etx_packet
);

  // Failures seen so far
  int   fail_count = 0;
  logic stalled;

  // Held packet blocked by the wait of its own direction
  assign stalled = etx_access & (etx_packet[WRITE_BIT] ? etx_wr_wait : etx_rd_wait);

  hold_stable: assert property (@(posedge clk) disable iff (rst)
    stalled |=> etx_access && $stable(etx_packet))
  else
  begin
    $error("held packet changed while stalled");
    fail_count++;
  end

  // At most one stream wins
  grant_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
  else
  begin
    $error("more than one stream granted");
    fail_count++;
  end

  no_grant_cfg: assert property (@(posedge clk) disable iff (rst) cfg_wait |-> grant == '0)
  else
  begin
    $error("grant while configuration wait is high");
    fail_count++;
  end

endmodule

bind tx_arbiter emesh_tx_sva sva0
(
  .clk(clk), .rst(rst), .grant(grant), .cfg_wait(cfg_wait), .etx_access(etx_access),
  .etx_wr_wait(etx_wr_wait), .etx_rd_wait(etx_rd_wait), .etx_packet(etx_packet)
);

// ==== verif/tb_emesh_tx.sv ====
// Testbench for the transmit path: stimulus, APB tasks, reference model, checker, watchdog
`timescale 1ns/1ps

module tb_emesh_tx import emesh_tx_pkg::*;
();

  // Traffic sizes per phase
  localparam int N_GATE = 4;
  localparam int N_RAND = 40;
  localparam int TOTAL_PKTS = NUM_CH * N_GATE + FIFO_DEPTH + 3 * NUM_CH * N_RAND;
  // 100 cycles per packet plus margin for register accesses
  localparam int LIMIT_CYCLES = 100 * TOTAL_PKTS + 2000;

  logic          clk;
  logic          rst;
  logic          txwr_access;
  logic [PW-1:0] txwr_packet;
  logic          txwr_wait;
  logic          txrd_access;
  logic [PW-1:0] txrd_packet;
  logic          txrd_wait;
  logic          txrr_access;
  logic [PW-1:0] txrr_packet;
  logic          txrr_wait;
  logic          etx_access;
  logic [PW-1:0] etx_packet;
  logic          etx_rr;
  logic          etx_wr_wait;
  logic          etx_rd_wait;
  logic [11:0]   paddr;
  logic          psel;
  logic          penable;
  logic          pwrite;
  logic [31:0]   pwdata;
  logic [31:0]   prdata;
  logic          pready;
  logic          pslverr;

  // Expected packets per stream, in push order
  logic [PW-1:0]         exp_q [NUM_CH][$];
  // Stream index of each handoff
  int                    order_log [$];
  int                    handoffs;
  integer                seed = 66;
  // Shadow of the control register
  logic                  bypass_sh;
  logic [CTRLMODE_W-1:0] mode_sh;
  logic                  bp_on;

  emesh_tx_top dut0 (.*);

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ############################
  // Helpers
  // ############################
  task automatic fail_now(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  // Control mode rule for one stream
  function automatic logic [PW-1:0] expected_packet(input logic [PW-1:0] pkt, input int ch,
                                                     input logic bypass,
                                                     input logic [CTRLMODE_W-1:0] mode);
    logic [PW-1:0] res;
    res = pkt;
    if (bypass && (ch != CH_RR))
    begin
      res[CTRLMODE_LSB +: CTRLMODE_W] = mode;
    end
    return res;
  endfunction

  task automatic make_packet(input int ch, output logic [PW-1:0] pkt);
    logic [127:0] raw;
    raw = {$random(seed), $random(seed), $random(seed), $random(seed)};
    pkt = raw[PW-1:0];
    // Only the write stream carries the write bit
    pkt[WRITE_BIT] = (ch == CH_WR);
  endtask

  task automatic drive_stream(input int ch, input logic acc, input logic [PW-1:0] pkt);
    case (ch)
      CH_WR:
      begin
        txwr_access <= acc;
        txwr_packet <= pkt;
      end
      CH_RD:
      begin
        txrd_access <= acc;
        txrd_packet <= pkt;
      end
      default:
      begin
        txrr_access <= acc;
        txrr_packet <= pkt;
      end
    endcase
  endtask

  function automatic logic stream_wait(input int ch);
    case (ch)
      CH_WR:   return txwr_wait;
      CH_RD:   return txrd_wait;
      default: return txrr_wait;
    endcase
  endfunction

  // One push where blocking keeps access up until the queue takes it
  task automatic push_one(input int ch, input logic [PW-1:0] pkt, input bit blocking,
                          output bit taken);
    taken = 1'b0;
    @(posedge clk);
    drive_stream(ch, 1'b1, pkt);
    forever
    begin
      @(negedge clk);
      if (!stream_wait(ch))
      begin
        taken = 1'b1;
        break;
      end
      if (!blocking)
      begin
        break;
      end
    end
    if (taken)
    begin
      exp_q[ch].push_back(expected_packet(pkt, ch, bypass_sh, mode_sh));
    end
    // Accepted at this edge when taken
    @(posedge clk);
    drive_stream(ch, 1'b0, pkt);
  endtask

  task automatic run_stream(input int ch, input int n, input bit gaps);
    logic [PW-1:0] pkt;
    bit            taken;
    int            gap;
    for (int i = 0; i < n; i++)
    begin
      make_packet(ch, pkt);
      push_one(ch, pkt, 1'b1, taken);
      gap = gaps ? ($random(seed) & 3) : 0;
      repeat (gap) @(posedge clk);
    end
  endtask

  task automatic run_traffic(input int n);
    fork
      run_stream(CH_WR, n, 1'b1);
      run_stream(CH_RD, n, 1'b1);
      run_stream(CH_RR, n, 1'b1);
    join
  endtask

  // Until every expected packet has left and the pins are idle
  task automatic wait_drain();
    do
    begin
      @(negedge clk);
    end
    while ((exp_q[CH_WR].size() != 0) || (exp_q[CH_RD].size() != 0)
           || (exp_q[CH_RR].size() != 0) || etx_access);
  endtask

  // ############################
  // APB master
  // ############################
  task automatic apb_write(input logic [11:0] addr, input logic [31:0] data, output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    err = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_read(input logic [11:0] addr, output logic [31:0] data, output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge clk);
    penable <= 1'b1;
    // Data valid in the access phase
    @(negedge clk);
    assert (pready) else fail_now("APB slave did not complete the access");
    data = prdata;
    err = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  // ############################
  // Pin side and checking
  // ############################

  // Random pin back-pressure
  always @(posedge clk)
  begin
    if (bp_on)
    begin
      etx_wr_wait <= (($random(seed) & 3) == 0);
      etx_rd_wait <= (($random(seed) & 3) == 0);
    end
    else
    begin
      etx_wr_wait <= 1'b0;
      etx_rd_wait <= 1'b0;
    end
  end

  // Handoff happens at the next edge
  always @(negedge clk)
  begin : compare_handoff
    int            ch;
    logic [PW-1:0] exp_pkt;
    if (!rst && etx_access && !(etx_packet[WRITE_BIT] ? etx_wr_wait : etx_rd_wait))
    begin
      ch = etx_rr ? CH_RR : (etx_packet[WRITE_BIT] ? CH_WR : CH_RD);
      assert (exp_q[ch].size() != 0)
      else fail_now($sformatf("packet sent on stream %0d that was never pushed", ch));
      exp_pkt = exp_q[ch].pop_front();
      assert (etx_packet === exp_pkt)
      else fail_now($sformatf("error: etx_packet 0x%h expected 0x%h", etx_packet, exp_pkt));
      order_log.push_back(ch);
      handoffs++;
    end
  end

  initial
  begin : watchdog
    repeat (LIMIT_CYCLES) @(posedge clk);
    $display("timeout: traffic did not finish within %0d cycles", LIMIT_CYCLES);
    $display("Simulation failed");
    $fatal(1);
  end

  // ############################
  // Test sequence
  // ############################
  initial
  begin : main_seq
    logic [31:0]   rd;
    logic          err;
    bit            taken;
    logic [PW-1:0] pkt;
    rst = 1'b1;
    {txwr_access, txrd_access, txrr_access} = '0;
    {txwr_packet, txrd_packet, txrr_packet} = '0;
    {etx_wr_wait, etx_rd_wait} = '0;
    {psel, penable, pwrite} = '0;
    paddr = '0;
    pwdata = '0;
    bypass_sh = 1'b0;
    mode_sh = '0;
    bp_on = 1'b0;
    handoffs = 0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    assert (!etx_access && !txwr_wait && !txrd_wait && !txrr_wait)
    else fail_now("outputs not idle after reset");

    // Transmit disabled holds every stream
    fork
      run_stream(CH_WR, N_GATE, 1'b0);
      run_stream(CH_RD, N_GATE, 1'b0);
      run_stream(CH_RR, N_GATE, 1'b0);
    join
    repeat (10)
    begin
      @(negedge clk);
      assert (!etx_access)
      else fail_now($sformatf("error: etx_access 0x%h expected 0x%h", etx_access, 1'b0));
    end
    apb_read(ADDR_STATUS, rd, err);
    assert (rd === 32'h7) else fail_now($sformatf("error: prdata 0x%h expected 0x%h", rd, 32'h7));
    apb_write(ADDR_CTRL, 32'h1, err);
    wait_drain();
    assert (order_log.size() == NUM_CH * N_GATE) else fail_now("wrong number of handoffs");
    foreach (order_log[i])
    begin
      assert (order_log[i] == i / N_GATE)
      else fail_now($sformatf("error: stream 0x%h expected 0x%h", order_log[i], i / N_GATE));
    end

    // Full write queue refuses one more
    apb_write(ADDR_CTRL, 32'h0, err);
    run_stream(CH_WR, FIFO_DEPTH, 1'b0);
    make_packet(CH_WR, pkt);
    push_one(CH_WR, pkt, 1'b0, taken);
    assert (!taken) else fail_now("push into a full write queue was accepted");
    apb_write(ADDR_CTRL, 32'h1, err);
    wait_drain();

    // Registers
    apb_read(ADDR_COUNT, rd, err);
    assert (rd === 32'(handoffs))
    else fail_now($sformatf("error: prdata 0x%h expected 0x%h", rd, 32'(handoffs)));
    apb_write(ADDR_COUNT, 32'hdead_beef, err);
    handoffs = 0;
    apb_read(ADDR_COUNT, rd, err);
    assert (rd === 32'h0) else fail_now($sformatf("error: prdata 0x%h expected 0x%h", rd, 32'h0));
    apb_write(ADDR_CTRL, 32'hffff_ffa3, err);
    apb_read(ADDR_CTRL, rd, err);
    assert (rd === 32'ha3) else fail_now($sformatf("error: prdata 0x%h expected 0x%h", rd, 32'ha3));
    assert (!err) else fail_now($sformatf("error: pslverr 0x%h expected 0x%h", err, 1'b0));
    apb_read(12'h00c, rd, err);
    assert (err) else fail_now($sformatf("error: pslverr 0x%h expected 0x%h", err, 1'b1));

    // Random traffic with bypass off then on
    apb_write(ADDR_CTRL, 32'h1, err);
    bypass_sh = 1'b0;
    run_traffic(N_RAND);
    wait_drain();
    apb_write(ADDR_CTRL, 32'h53, err);
    bypass_sh = 1'b1;
    mode_sh = 4'h5;
    run_traffic(N_RAND);
    wait_drain();

    // Pin back-pressure
    bp_on = 1'b1;
    run_traffic(N_RAND);
    wait_drain();
    bp_on = 1'b0;
    apb_read(ADDR_COUNT, rd, err);
    assert (rd === 32'(handoffs))
    else fail_now($sformatf("error: prdata 0x%h expected 0x%h", rd, 32'(handoffs)));

    repeat (4) @(posedge clk);
    if (dut0.u_arb.sva0.fail_count == 0)
    begin
      $display("Simulation passed");
      $finish;
    end
    else
    begin
      $display("Simulation failed");
      $fatal(1);
    end
  end

endmodule
